/* common/fma_pkg.sv */
package fma_pkg;

    localparam int ACC_W = 77;              // Sign bit plus 76 magnitude bits

    typedef logic [31:0]               fp32_t;
    typedef logic signed [9:0]         expo_t;   // Virtual exponent, may go below 1 or above 254
    typedef logic [23:0]               mant_t;   // Significand with hidden bit
    typedef logic signed [ACC_W-1:0]   acc_t;
    typedef logic [ACC_W-2:0]          mag_t;
    typedef logic [6:0]                shamt_t;
    typedef logic [2:0]                rmode_t;
    typedef logic [4:0]                fflags_t; // NV DZ OF UF NX

    localparam int    EXP_BIAS  = 127;
    localparam int    EXP_INF   = 255;
    localparam fp32_t CANON_NAN = 32'h7fc0_0000;

    // RISC-V rounding-mode encodings
    localparam rmode_t RM_RNE = 3'd0;
    localparam rmode_t RM_RTZ = 3'd1;
    localparam rmode_t RM_RDN = 3'd2;
    localparam rmode_t RM_RUP = 3'd3;
    localparam rmode_t RM_RMM = 3'd4;

    // Accumulator bits above the product, which sits three bits up from bit 0
    localparam int PRODUCT_OFFSET = 26;

    localparam int FMA_LATENCY = 4;

    // Side information that rides along with each operation
    typedef struct packed {
        logic   valid;
        rmode_t rm;
        logic   is_nan;           // Result is the canonical NaN
        logic   is_inf;           // Result is an infinity
        logic   inf_sign;
        logic   res_is_addend;    // Product is zero, addend is not
        logic   product_is_tiny;  // Product below half an ulp of the addend
        logic   res_is_tiny;      // Addend zero, product below half the smallest subnormal
        logic   invalid;
        logic   is_subtract;      // Product and addend have opposite signs
        logic   prod_sign;
        fp32_t  addend;
        expo_t  prod_expo;        // Exponent of the accumulator's top bit
    } spec_t;

    // After the multiply-accumulate
    typedef struct packed {
        spec_t spec;
        mag_t  mag;
        logic  is_zero;
        logic  sign;
    } acc_stage_t;

    // After leading-zero count
    typedef struct packed {
        acc_stage_t acc;
        shamt_t     shift;
        expo_t      vexp;
        logic       subnormal;
    } norm_stage_t;

endpackage

/* fma_core/fma_unpack.sv */
`timescale 1ns/1ps

module fma_unpack import fma_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  fp32_t a,
    input  fp32_t b,
    input  fp32_t c,
    input  rmode_t rm,
    output spec_t spec,
    output acc_t  op_a,
    output acc_t  op_b,
    output acc_t  op_c
);

    fp32_t       opnd [3];      // 0 = a, 1 = b, 2 = c
    logic [2:0]  is_zero;
    logic [2:0]  is_inf;
    logic [2:0]  is_nan;
    logic [2:0]  is_snan;
    expo_t       vexp [3];
    mant_t       vmant [3];

    logic        prod_zero;
    logic        prod_inf;
    logic        prod_sign;
    logic        is_subtract;
    logic        invalid;
    expo_t       prod_expo;
    expo_t       addend_shift;
    logic [74:0] addend_aligned;
    logic        addend_sticky;
    spec_t       spec_d;

    always_comb begin
        opnd[0] = a;
        opnd[1] = b;
        opnd[2] = c;
        for (int i = 0; i < 3; i++) begin
            is_zero[i] = opnd[i][30:0] == 31'h0;
            is_inf[i]  = opnd[i][30:23] == 8'hff && opnd[i][22:0] == 23'h0;
            is_nan[i]  = opnd[i][30:23] == 8'hff && opnd[i][22:0] != 23'h0;
            is_snan[i] = is_nan[i] && !opnd[i][22];  // Quiet bit clear
            // Subnormals share the exponent of the smallest normal
            vexp[i]    = (opnd[i][30:23] == 8'h00) ? 10'sd1 : expo_t'({2'b00, opnd[i][30:23]});
            vmant[i]   = {opnd[i][30:23] != 8'h00, opnd[i][22:0]};
        end
    end

    assign prod_sign   = a[31] ^ b[31];
    assign is_subtract = prod_sign ^ c[31];
    assign prod_zero   = is_zero[0] | is_zero[1];
    assign prod_inf    = (is_inf[0] & !is_nan[1]) | (is_inf[1] & !is_nan[0]);

    // RISC-V raises NV on inf*0 even with a quiet NaN addend
    assign invalid = (|is_snan)
                   | (is_zero[0] & is_inf[1]) | (is_inf[0] & is_zero[1])
                   | (is_subtract & prod_inf & is_inf[2]);   // inf - inf

    assign prod_expo    = expo_t'(vexp[0] + vexp[1] - EXP_BIAS + PRODUCT_OFFSET);
    assign addend_shift = prod_expo - vexp[2];

    // Addend lands with its LSB at accumulator bit 52 when the shift is zero
    always_comb begin
        addend_aligned = {vmant[2], 51'b0} >> addend_shift;
        if (addend_shift > 10'sd75) begin
            addend_sticky = |vmant[2];
        end else begin
            addend_sticky = |mant_t'(vmant[2] << (75 - addend_shift));  // Bits shifted out
        end
    end

    always_comb begin
        spec_d                 = '0;
        spec_d.valid           = in_valid;
        spec_d.rm              = rm;
        spec_d.is_nan          = (|is_nan) | invalid;
        spec_d.is_inf          = |is_inf;
        spec_d.inf_sign        = is_inf[2] ? c[31] : prod_sign;
        spec_d.res_is_addend   = prod_zero & !is_zero[2];
        spec_d.product_is_tiny = addend_shift < 0 && !prod_zero && !is_zero[2];
        spec_d.res_is_tiny     = addend_shift < 0 && !prod_zero && is_zero[2];
        spec_d.invalid         = invalid;
        spec_d.is_subtract     = is_subtract;
        spec_d.prod_sign       = prod_sign;
        spec_d.addend          = c;
        spec_d.prod_expo       = prod_expo;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spec.valid <= 1'b0;
        end else begin
            spec <= spec_d;
        end
    end

    // Guard offsets put the product three bits above bit 0
    always_ff @(posedge clk) begin
        op_a <= {51'b0, vmant[0], 2'b0};
        op_b <= {52'b0, vmant[1], 1'b0};
        op_c <= {1'b0, addend_aligned, addend_sticky};
    end

endmodule

/* fma_core/fma_mac.sv */
`timescale 1ns/1ps

module fma_mac import fma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  spec_t      spec_in,
    input  acc_t       op_a,
    input  acc_t       op_b,
    input  acc_t       op_c,
    output acc_stage_t acc_out
);

    spec_t spec_q;
    acc_t  sum_q;
    logic  sum_neg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spec_q.valid <= 1'b0;
        end else begin
            spec_q <= spec_in;
        end
    end

    // Product stays below 2^51, so 76 magnitude bits never overflow
    always_ff @(posedge clk) begin
        if (spec_in.is_subtract) begin
            sum_q <= op_a * op_b - op_c;
        end else begin
            sum_q <= op_a * op_b + op_c;
        end
    end

    assign sum_neg = sum_q[ACC_W-1];

    always_comb begin
        acc_out         = '0;
        acc_out.spec    = spec_q;
        acc_out.mag     = sum_neg ? -sum_q[ACC_W-2:0] : sum_q[ACC_W-2:0];
        acc_out.is_zero = sum_q == '0;
        acc_out.sign    = spec_q.prod_sign ^ sum_neg;  // Addend won the subtraction
    end

endmodule

/* fma_core/fma_normalize.sv */
`timescale 1ns/1ps

module fma_normalize import fma_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  acc_stage_t  acc_in,
    output norm_stage_t norm_out
);

    function automatic shamt_t count_lz(mag_t x);
        shamt_t n;
        n = shamt_t'(ACC_W - 1);       // All zero
        for (int i = 0; i < ACC_W - 1; i++) begin
            if (x[i]) n = shamt_t'(ACC_W - 2 - i);  // Highest set bit wins
        end
        return n;
    endfunction

    shamt_t      lz;
    norm_stage_t norm_d;

    assign lz = count_lz(acc_in.mag);

    always_comb begin
        norm_d           = '0;
        norm_d.acc       = acc_in;
        norm_d.vexp      = acc_in.spec.prod_expo - expo_t'({3'b000, lz});
        norm_d.subnormal = norm_d.vexp <= 0;
        // Subnormals stop at the minimum exponent instead of at the leading one
        norm_d.shift     = norm_d.subnormal ? acc_in.spec.prod_expo[6:0] : lz + 7'd1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_out.acc.spec.valid <= 1'b0;
        end else begin
            norm_out <= norm_d;
        end
    end

endmodule

/* fma_core/fma_round.sv */
`timescale 1ns/1ps

module fma_round import fma_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  norm_stage_t norm_in,
    output logic        out_valid,
    output fp32_t       result,
    output fflags_t     flags
);

    function automatic logic round_up(rmode_t mode, logic sign, logic lsb,
                                      logic guard, logic sticky);
        case (mode)
            RM_RNE:  return guard & (lsb | sticky);   // Ties to even
            RM_RMM:  return guard;                    // Ties away
            RM_RDN:  return sign & (guard | sticky);
            RM_RUP:  return !sign & (guard | sticky);
            default: return 1'b0;                     // Toward zero
        endcase
    endfunction

    spec_t       spec;
    mag_t        mag;
    logic        sign;
    logic        addend_sign;

    logic [24:0] frac;         // 23 mantissa bits, guard, extra guard
    logic        sticky;
    logic        round_away;
    logic        carry;
    logic        u_round_away;
    logic        u_carry;
    logic [22:0] res_mant;
    logic [7:0]  res_expo;

    logic        res_is_huge;
    logic        dir_is_away;
    logic        huge_is_inf;
    logic        nudge_down;
    logic        nudge_up;
    fp32_t       addend_nudged;
    fp32_t       huge_val;
    fp32_t       tiny_val;
    fp32_t       zero_val;
    fp32_t       result_d;

    logic        overflow;
    logic        underflow;
    logic        inexact;

    assign spec        = norm_in.acc.spec;
    assign mag         = norm_in.acc.mag;
    assign sign        = norm_in.acc.sign;
    assign addend_sign = spec.addend[31];

    // Left-normalize by shifting the widened magnitude right
    assign frac   = 25'({mag, 24'b0} >> (7'd75 - norm_in.shift));
    assign sticky = mag_t'(mag << (25 + int'(norm_in.shift))) != '0;

    assign round_away = round_up(spec.rm, sign, frac[2], frac[1], frac[0] | sticky);
    assign carry      = frac >= 25'h1ff_fffc && round_away;

    // Same decision one bit lower, as if the exponent range were unbounded
    assign u_round_away = round_up(spec.rm, sign, frac[1], frac[0], sticky);
    assign u_carry      = frac >= 25'h1ff_fffe && u_round_away;

    assign res_mant = frac[24:2] + {22'h0, round_away};  // Wraps to zero on carry
    assign res_expo = (norm_in.subnormal ? 8'h00 : norm_in.vexp[7:0]) + {7'b0, carry};

    assign res_is_huge = norm_in.vexp >= EXP_INF;
    assign dir_is_away = (spec.rm == RM_RDN && sign) || (spec.rm == RM_RUP && !sign);
    assign huge_is_inf = spec.rm == RM_RNE || spec.rm == RM_RMM || dir_is_away;

    // A tiny product only moves the addend in the directed modes
    assign nudge_down = spec.is_subtract && (spec.rm == RM_RTZ
                        || (spec.rm == RM_RDN && !addend_sign)
                        || (spec.rm == RM_RUP && addend_sign));
    assign nudge_up   = !spec.is_subtract && ((spec.rm == RM_RDN && addend_sign)
                        || (spec.rm == RM_RUP && !addend_sign));

    always_comb begin
        if (nudge_down) begin
            addend_nudged = spec.addend - 32'd1;
        end else if (nudge_up) begin
            addend_nudged = spec.addend + 32'd1;
        end else begin
            addend_nudged = spec.addend;
        end
    end

    assign huge_val = huge_is_inf ? {sign, 8'(EXP_INF), 23'h0}
                                  : {sign, 8'(EXP_INF - 1), {23{1'b1}}};
    assign tiny_val = {sign, 8'h00, 22'h0, dir_is_away};
    // Exact zero sum: opposite signs give +0 except in round-down
    assign zero_val = {spec.is_subtract ? spec.rm == RM_RDN : addend_sign, 31'h0};

    always_comb begin
        if (spec.is_nan) begin
            result_d = CANON_NAN;
        end else if (spec.is_inf) begin
            result_d = {spec.inf_sign, 8'(EXP_INF), 23'h0};
        end else if (res_is_huge) begin
            result_d = huge_val;
        end else if (spec.res_is_tiny) begin
            result_d = tiny_val;
        end else if (spec.product_is_tiny) begin
            result_d = addend_nudged;
        end else if (spec.res_is_addend) begin
            result_d = spec.addend;
        end else if (norm_in.acc.is_zero) begin
            result_d = zero_val;
        end else begin
            result_d = {sign, res_expo, res_mant};
        end
    end

    assign overflow = !spec.is_nan && !spec.is_inf
                      && (spec.product_is_tiny ? addend_nudged[30:23] == 8'hff
                          : res_is_huge || (norm_in.vexp == EXP_INF - 1 && carry));
    assign inexact  = !spec.is_nan && !spec.is_inf
                      && (overflow || spec.res_is_tiny || spec.product_is_tiny
                          || frac[1] || frac[0] || sticky);
    // Tininess after rounding
    assign underflow = inexact
                       && (spec.product_is_tiny
                           ? (spec.addend[30:23] == 8'h00 || addend_nudged[30:23] == 8'h00)
                           : (spec.res_is_tiny || (norm_in.subnormal && !u_carry)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= spec.valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= result_d;
        flags  <= {spec.invalid, 1'b0, overflow, underflow, inexact};  // DZ never set
    end

endmodule

/* src/fp32_fma.sv */
`timescale 1ns/1ps

module fp32_fma import fma_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  fp32_t   a,
    input  fp32_t   b,
    input  fp32_t   c,
    input  rmode_t  rm,
    output logic    out_valid,
    output fp32_t   result,
    output fflags_t flags
);

    spec_t       spec;
    acc_t        op_a;
    acc_t        op_b;
    acc_t        op_c;
    acc_stage_t  acc_stage;
    norm_stage_t norm_stage;

    // Stage 1: classify and align
    fma_unpack u_unpack (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .c        (c),
        .rm       (rm),
        .spec     (spec),
        .op_a     (op_a),
        .op_b     (op_b),
        .op_c     (op_c)
    );

    // Stage 2: wide multiply-accumulate
    fma_mac u_mac (
        .clk     (clk),
        .rst_n   (rst_n),
        .spec_in (spec),
        .op_a    (op_a),
        .op_b    (op_b),
        .op_c    (op_c),
        .acc_out (acc_stage)
    );

    // Stage 3
    fma_normalize u_normalize (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_in   (acc_stage),
        .norm_out (norm_stage)
    );

    // Stage 4: round, special results and flags
    fma_round u_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .norm_in   (norm_stage),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

endmodule

/* testbench/fma_ref.svh */
`ifndef FMA_REF_SVH
`define FMA_REF_SVH

// Whether the kept value moves one step away from zero
function automatic logic round_incr(rmode_t mode, logic sign, logic lsb, logic half,
                                    logic rest);
    case (mode)
        RM_RNE:  return half && (lsb || rest);
        RM_RDN:  return sign && (half || rest);
        RM_RUP:  return !sign && (half || rest);
        RM_RMM:  return half;
        default: return 1'b0;
    endcase
endfunction

// Exact a*b+c with a single rounding, returned as {result, flags}
function automatic logic [36:0] fma_ref(fp32_t a, fp32_t b, fp32_t c, rmode_t mode);
    logic [639:0] prod;
    logic [639:0] addend;
    logic [639:0] mag;
    logic [639:0] kept;
    logic [23:0]  ma, mb, mc;
    logic [24:0]  q;
    logic         a_nan, b_nan, c_nan, a_inf, b_inf, c_inf, a_zero, b_zero;
    logic         sp, sign, p_inf, invalid, half, rest, inexact, tiny, to_inf;
    int           ea, eb, ec, top, lsb_pos, expo;
    a_nan   = a[30:23] == 8'hff && a[22:0] != 23'h0;
    b_nan   = b[30:23] == 8'hff && b[22:0] != 23'h0;
    c_nan   = c[30:23] == 8'hff && c[22:0] != 23'h0;
    a_inf   = a[30:0] == 31'h7f80_0000;
    b_inf   = b[30:0] == 31'h7f80_0000;
    c_inf   = c[30:0] == 31'h7f80_0000;
    a_zero  = a[30:0] == 31'h0;
    b_zero  = b[30:0] == 31'h0;
    sp      = a[31] ^ b[31];
    p_inf   = (a_inf || b_inf) && !a_nan && !b_nan;
    invalid = (a_nan && !a[22]) || (b_nan && !b[22]) || (c_nan && !c[22])
              || (a_inf && b_zero) || (a_zero && b_inf) || (p_inf && c_inf && sp != c[31]);
    if (invalid || a_nan || b_nan || c_nan) return {CANON_NAN, invalid, 4'b0000};
    if (c_inf) return {c, 5'b00000};
    if (p_inf) return {sp, 8'hff, 23'h0, 5'b00000};

    ea = (a[30:23] == 8'h00) ? 1 : int'(a[30:23]);
    eb = (b[30:23] == 8'h00) ? 1 : int'(b[30:23]);
    ec = (c[30:23] == 8'h00) ? 1 : int'(c[30:23]);
    ma = {a[30:23] != 8'h00, a[22:0]};
    mb = {b[30:23] != 8'h00, b[22:0]};
    mc = {c[30:23] != 8'h00, c[22:0]};
    // Everything scaled by 2^298, the weight of the smallest product bit
    prod   = 640'(ma) * 640'(mb);
    prod   = prod << (ea + eb - 2);
    addend = 640'(mc) << (ec + 148);
    if (sp == c[31] || prod >= addend) begin
        mag  = (sp == c[31]) ? prod + addend : prod - addend;
        sign = sp;
    end else begin
        mag  = addend - prod;
        sign = c[31];
    end
    if (mag == '0) return {(sp == c[31]) ? sp : (mode == RM_RDN), 31'h0, 5'b00000};

    top = 0;
    for (int i = 0; i < 640; i++) begin
        if (mag[i]) top = i;
    end
    lsb_pos = (top - 23 > 149) ? top - 23 : 149;  // Bit 149 weighs one subnormal ulp
    kept    = mag >> lsb_pos;
    half    = mag[lsb_pos - 1];
    rest    = (mag << (641 - lsb_pos)) != '0;
    inexact = half || rest;
    q       = 25'(kept) + 25'(round_incr(mode, sign, kept[0], half, rest));
    if (q[24]) begin
        q = q >> 1;
        lsb_pos++;
    end
    expo = q[23] ? lsb_pos - 148 : 0;
    if (expo >= 255) begin
        to_inf = mode == RM_RNE || mode == RM_RMM || (mode == RM_RDN && sign)
                 || (mode == RM_RUP && !sign);
        return to_inf ? {sign, 8'hff, 23'h0, 5'b00101} : {sign, 8'hfe, 23'h7f_ffff, 5'b00101};
    end
    // Tiny when 24-bit rounding with no exponent floor stays below 2^-126
    tiny = top < 171;
    if (top == 171) begin
        tiny = !(&mag[171:148] && round_incr(mode, sign, 1'b1, mag[147], (mag << 493) != '0));
    end
    return {sign, 8'(expo), q[22:0], 3'b000, tiny && inexact, inexact};
endfunction

`endif

/* testbench/tb_fma.sv */
`timescale 1ns/1ps

module tb_fma import fma_pkg::*; ();

    `include "fma_ref.svh"

    localparam int RESET_CYCLES = 5;
    localparam int N_DIRECTED   = 71;
    localparam int N_RANDOM     = 3000;
    localparam int MAX_GAP      = 3;
    // Every random operation followed by the longest gap
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 4 + N_DIRECTED + N_RANDOM * (MAX_GAP + 1)
                                  + FMA_LATENCY + 20;

    typedef struct packed {
        fp32_t       result;
        fflags_t     flags;
        logic [31:0] cycle;    // Cycle in which in_valid was high
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    fp32_t       a;
    fp32_t       b;
    fp32_t       c;
    rmode_t      rm;
    logic        out_valid;
    fp32_t       result;
    fflags_t     flags;
    logic [31:0] lcg_state = 32'hab6d;
    logic [31:0] cycle = '0;
    expect_t     expected_q [$];

    fp32_fma DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .rm        (rm),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the DUT did not return all results within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    // Low bits of a power-of-two LCG cycle quickly, so the upper half is folded in
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    task automatic check_result(fp32_t got, fp32_t expected);
        if (got !== expected) begin
            $display("error @%0t ns: result %h, expected %h", $time, got, expected);
            $display("Result: FAILED");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flags(fflags_t got, fflags_t expected);
        if (got !== expected) begin
            $display("error @%0t ns: flags %b, expected %b", $time, got, expected);
            $display("Result: FAILED");
            $fatal(1, "flags mismatch");
        end
    endtask

    task automatic check_latency(logic [31:0] issued);
        if (cycle - issued != FMA_LATENCY) begin
            $display("A result came %0d cycles after its operation instead of %0d",
                     cycle - issued, FMA_LATENCY);
            $display("Result: FAILED");
            $fatal(1, "latency");
        end
    endtask

    // Inputs and outputs are both stable at the falling edge
    always @(negedge clk) begin : monitor
        expect_t entry;
        if (in_valid) begin
            {entry.result, entry.flags} = fma_ref(a, b, c, rm);
            entry.cycle = cycle;
            expected_q.push_back(entry);
        end
        if (out_valid !== 1'b0) begin
            if (out_valid !== 1'b1 || !rst_n || expected_q.size() == 0) begin
                $display("out_valid was high or unknown at %0t ns with nothing in flight", $time);
                $display("Result: FAILED");
                $fatal(1, "stray out_valid");
            end else begin
                entry = expected_q.pop_front();
                check_latency(entry.cycle);
                check_result(result, entry.result);
                check_flags(flags, entry.flags);
            end
        end
    end

    task automatic issue_op(fp32_t x, fp32_t y, fp32_t z, rmode_t mode);
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= x;
        b        <= y;
        c        <= z;
        rm       <= mode;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic run_directed();
        issue_op(32'h7fc0_0001, 32'h3f80_0000, 32'h3f80_0000, RM_RNE);  // Quiet NaN
        issue_op(32'h3f80_0000, 32'h7f80_0001, 32'h3f80_0000, RM_RNE);  // Signalling NaN
        issue_op(32'h7f80_0001, 32'h3f80_0000, 32'h3f80_0000, RM_RNE);
        issue_op(32'h3f80_0000, 32'h7fc0_0000, 32'h3f80_0000, RM_RNE);
        issue_op(32'h3f80_0000, 32'h3f80_0000, 32'h7fa0_0000, RM_RNE);
        issue_op(32'h3f80_0000, 32'h3f80_0000, 32'hffc1_2345, RM_RNE);
        issue_op(32'h7f80_0000, 32'h0000_0000, 32'h7fc0_0000, RM_RNE);  // inf*0 + qNaN
        issue_op(32'h0000_0000, 32'hff80_0000, 32'h3f80_0000, RM_RNE);
        issue_op(32'h7f80_0000, 32'h3f80_0000, 32'hff80_0000, RM_RNE);  // inf - inf
        issue_op(32'h7f80_0000, 32'hc000_0000, 32'h3f80_0000, RM_RNE);
        issue_op(32'h3f80_0000, 32'h3f80_0000, 32'hff80_0000, RM_RNE);
        for (int m = 0; m < 5; m++) begin
            // Overflow
            issue_op(32'h7f7f_ffff, 32'h4000_0000, 32'h0000_0000, rmode_t'(m));
            issue_op(32'hff7f_ffff, 32'h4000_0000, 32'h3f80_0000, rmode_t'(m));
            // Product far below the addend
            issue_op(32'h3f80_0000, 32'h0000_0001, 32'h3f80_0000, rmode_t'(m));
            issue_op(32'h3f80_0000, 32'h8000_0001, 32'h3f80_0000, rmode_t'(m));
            issue_op(32'h3f80_0000, 32'h0000_0001, 32'hbf80_0000, rmode_t'(m));
            // Subnormal results
            issue_op(32'h0080_0000, 32'h3f00_0001, 32'h0000_0000, rmode_t'(m));
            issue_op(32'h0080_0001, 32'h3f00_0000, 32'h8000_0000, rmode_t'(m));
            issue_op(32'h00ff_ffff, 32'h3f00_0000, 32'h0000_0000, rmode_t'(m));
            // Exact cancellation and signed zeros
            issue_op(32'h3fc0_0000, 32'h4000_0000, 32'hc040_0000, rmode_t'(m));
            issue_op(32'h0000_0000, 32'h0000_0000, 32'h0000_0000, rmode_t'(m));
            issue_op(32'h8000_0000, 32'h0000_0000, 32'h8000_0000, rmode_t'(m));
            issue_op(32'h0000_0000, 32'h3f80_0000, 32'h8000_0000, rmode_t'(m));
        end
    endtask

    task automatic run_random();
        fp32_t       x, y, z;
        logic [31:0] r;
        int          ez;
        for (int i = 0; i < N_RANDOM; i++) begin
            x = lcg_next();
            y = lcg_next();
            z = lcg_next();
            r = lcg_next();
            if (r[2:0] inside {3'd2, 3'd3, 3'd4}) begin  // Addend near the product
                ez = int'(x[30:23]) + int'(y[30:23]) - EXP_BIAS + int'(r[7:4]) - 8;
                z[30:23] = (ez < 0) ? 8'd0 : (ez > 254) ? 8'd254 : 8'(ez);
            end else if (r[2:0] == 3'd5) begin
                // Product and addend around the smallest normal
                x[30:23] = 8'(r[9:4]);
                y[30:23] = 8'(110 - int'(r[9:4]) + int'(r[14:11]));
                z[30:23] = 8'(r[17:15]);
            end
            issue_op(x, y, z, rmode_t'(r[31:16] % 5));
            if (r[3]) idle(int'(r[13:12]));
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        c        = '0;
        rm       = RM_RNE;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        idle(2);
        run_directed();
        idle(1);
        run_random();
        idle(1);
        while (expected_q.size() != 0) @(posedge clk);
        idle(FMA_LATENCY + 2);  // Room for a stray out_valid to show up
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+testbench
common/fma_pkg.sv
fma_core/fma_unpack.sv
fma_core/fma_mac.sv
fma_core/fma_normalize.sv
fma_core/fma_round.sv
src/fp32_fma.sv
testbench/tb_fma.sv

/* Makefile */
# Verilator simulation of the FMA testbench

VERILATOR ?= verilator
TOP       ?= tb_fma
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

# A failing run stops with $fatal, so the binary's exit status fails the target
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
